//--- common/bus_pkg.sv
// Bus-side types for the LSU data port
// Word, address and byte-enable vectors plus the RAM request and response
`default_nettype none

package bus_pkg;

    // --------------------
    // Widths
    // --------------------

    // RV32 data path
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    // One enable per byte lane
    localparam int LANES = DATA_W / 8;

    // --------------------
    // Vector types
    // --------------------

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LANES-1:0]  byte_en_t;

    // --------------------
    // Bus structs
    // --------------------

    // Request from LSU to RAM, no waitrequest
    typedef struct packed {
        logic     read;
        logic     write;
        addr_t    address;
        byte_en_t byte_enable;
        // Already steered onto the enabled lanes
        word_t    writedata;
    } bus_req_t;

    // Raw read word, one cycle after the read
    typedef struct packed {
        word_t readdata;
        logic  readdatavalid;
    } bus_rsp_t;

endpackage

`default_nettype wire

//--- common/lsu_pkg.sv
// Core-side types for the load/store unit
// Opcode and exception encodings, core request and response structs
`default_nettype none

package lsu_pkg;

    import bus_pkg::*;

    // --------------------
    // Opcode
    // --------------------

    // Bit 2 set selects zero extension
    // Bits 1:0 hold the access size
    // Stores reuse the load codes, bit 2 ignored
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } mem_op_t;

    // Size field values, op[1:0]
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    // --------------------
    // Exceptions
    // --------------------

    typedef enum logic [1:0] {
        NONE             = 2'd0,
        LOAD_MISALIGNED  = 2'd1,
        STORE_MISALIGNED = 2'd2
    } mem_exc_t;

    // --------------------
    // Core structs
    // --------------------

    typedef struct packed {
        logic    is_store;
        mem_op_t op;
        addr_t   address;
        word_t   wdata;
    } lsu_req_t;

    // rdata is only meaningful for loads with no exception
    typedef struct packed {
        word_t    rdata;
        mem_exc_t exc;
    } lsu_rsp_t;

endpackage

`default_nettype wire

//--- lsu/lsu_request.sv
// LSU request side
// Accepts core requests, checks alignment and drives the RAM bus request
// with byte enables and lane-steered store data
`timescale 1ns/100ps
`default_nettype none

module lsu_request import bus_pkg::*, lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  lsu_req_t   req,
    input  logic       req_valid,
    output logic       req_ready,
    input  logic       rsp_busy,
    input  logic       rsp_ready,
    output bus_req_t   bus_req,
    output logic       issue_valid,
    output mem_op_t    issue_op,
    output logic [1:0] issue_byte_addr,
    output mem_exc_t   issue_exc
);

    logic [1:0] size;
    logic [1:0] byte_addr;
    logic       misaligned;
    logic       accept;

    assign size      = req.op[1:0];
    assign byte_addr = req.address[1:0];

    // --------------------
    // Acceptance
    // --------------------

    // Stall only while a response sits unclaimed
    assign req_ready = ~(rsp_busy & ~rsp_ready);
    assign accept    = req_valid & req_ready;

    // --------------------
    // Alignment
    // --------------------

    always_comb begin
        case (size)
            SIZE_BYTE: misaligned = 1'b0;
            SIZE_HALF: misaligned = byte_addr[0];
            default:   misaligned = (byte_addr != 2'b00);
        endcase
    end

    // --------------------
    // Bus request
    // --------------------

    // Misaligned accesses never reach the RAM
    assign bus_req.read    = accept & ~req.is_store & ~misaligned;
    assign bus_req.write   = accept & req.is_store & ~misaligned;
    assign bus_req.address = req.address;

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                bus_req.byte_enable = byte_en_t'(4'b0001 << byte_addr);
                // Same byte on every lane, enable picks one
                bus_req.writedata   = {4{req.wdata[7:0]}};
            end
            SIZE_HALF: begin
                bus_req.byte_enable = byte_addr[1] ? 4'b1100 : 4'b0011;
                bus_req.writedata   = {2{req.wdata[15:0]}};
            end
            default: begin
                bus_req.byte_enable = 4'b1111;
                bus_req.writedata   = req.wdata;
            end
        endcase
    end

    // --------------------
    // Issue to load align
    // --------------------

    assign issue_valid     = accept;
    assign issue_op        = req.op;
    assign issue_byte_addr = byte_addr;
    assign issue_exc       = !misaligned  ? NONE :
                             req.is_store ? STORE_MISALIGNED : LOAD_MISALIGNED;

    // Waiting core request keeps valid and payload
    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req)
    );

endmodule

`default_nettype wire

//--- lsu/lsu_load_align.sv
// LSU response side
// Realigns and extends the raw RAM word into the core response
// Holds the response under back-pressure
`timescale 1ns/100ps
`default_nettype none

module lsu_load_align import bus_pkg::*, lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  bus_rsp_t   bus_rsp,
    input  logic       issue_valid,
    input  mem_op_t    issue_op,
    input  logic [1:0] issue_byte_addr,
    input  mem_exc_t   issue_exc,
    input  logic       rsp_ready,
    output lsu_rsp_t   rsp,
    output logic       rsp_valid,
    output logic       rsp_busy
);

    // First response cycle
    logic       pend_q;
    // Response parked under back-pressure
    logic       hold_q;
    mem_op_t    op_q;
    logic [1:0] byte_q;
    mem_exc_t   exc_q;
    lsu_rsp_t   hold_rsp_q;
    lsu_rsp_t   rsp_now;
    word_t      raw;
    logic       sign_ext;
    logic [15:0] half_sel;
    logic [7:0] byte_sel;

    // --------------------
    // Capture
    // --------------------

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            op_q   <= issue_op;
            byte_q <= issue_byte_addr;
            exc_q  <= issue_exc;
        end
        if (pend_q && !rsp_ready) begin
            hold_rsp_q <= rsp_now;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q <= 1'b0;
            hold_q <= 1'b0;
        end else begin
            pend_q <= issue_valid;
            if (pend_q && !rsp_ready) begin
                hold_q <= 1'b1;
            end else if (rsp_ready) begin
                hold_q <= 1'b0;
            end
        end
    end

    // --------------------
    // Realign and extend
    // --------------------

    always_comb begin
        // Stores and exceptions read nothing, return zero
        raw      = bus_rsp.readdatavalid ? bus_rsp.readdata : '0;
        sign_ext = ~op_q[2];
        half_sel = byte_q[1] ? raw[31:16] : raw[15:0];
        byte_sel = raw[8*byte_q +: 8];
        case (op_q[1:0])
            SIZE_WORD: rsp_now.rdata = raw;
            SIZE_HALF: rsp_now.rdata = {{16{sign_ext & half_sel[15]}}, half_sel};
            default:   rsp_now.rdata = {{24{sign_ext & byte_sel[7]}}, byte_sel};
        endcase
        rsp_now.exc = exc_q;
    end

    assign rsp       = hold_q ? hold_rsp_q : rsp_now;
    assign rsp_valid = pend_q | hold_q;
    // Output occupied, blocks new requests unless taken this edge
    assign rsp_busy  = pend_q | hold_q;

    // Stalled response keeps its payload
    a_rsp_stable: assert property (
        @(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
    );

endmodule

`default_nettype wire

//--- source/data_ram.sv
// Data RAM slave
// Byte-writable word memory, read data registered one cycle after the read
`timescale 1ns/100ps
`default_nettype none

module data_ram import bus_pkg::*; #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic     clk,
    input  bus_req_t bus_req,
    output bus_rsp_t bus_rsp
);

    localparam int WORDS = 2 ** DEPTH_LOG2;

    word_t                 mem [WORDS];
    logic [DEPTH_LOG2-1:0] word_idx;
    bus_rsp_t              rsp_q;

    // Word index above the byte offset, upper bits wrap
    assign word_idx = bus_req.address[DEPTH_LOG2+1:2];

    // --------------------
    // Write port
    // --------------------

    always_ff @(posedge clk) begin
        if (bus_req.write) begin
            for (int i = 0; i < LANES; i++) begin
                if (bus_req.byte_enable[i]) begin
                    mem[word_idx][8*i +: 8] <= bus_req.writedata[8*i +: 8];
                end
            end
        end
    end

    // --------------------
    // Read port
    // --------------------

    // Full word back, lane selection happens in the LSU
    always_ff @(posedge clk) begin
        rsp_q.readdatavalid <= bus_req.read;
        if (bus_req.read) begin
            rsp_q.readdata <= mem[word_idx];
        end
    end

    assign bus_rsp = rsp_q;

endmodule

`default_nettype wire

//--- source/lsu_top.sv
// Load/store unit top level
// Request side, response side and the data RAM behind them
`timescale 1ns/100ps
`default_nettype none

module lsu_top import bus_pkg::*, lsu_pkg::*; #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  lsu_req_t req,
    input  logic     req_valid,
    output logic     req_ready,
    output lsu_rsp_t rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready
);

    bus_req_t   bus_req;
    bus_rsp_t   bus_rsp;
    logic       issue_valid;
    mem_op_t    issue_op;
    logic [1:0] issue_byte_addr;
    mem_exc_t   issue_exc;
    logic       rsp_busy;

    lsu_request lsu_request_i (
        .clk             (clk),
        .rst             (rst),
        .req             (req),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .rsp_busy        (rsp_busy),
        .rsp_ready       (rsp_ready),
        .bus_req         (bus_req),
        .issue_valid     (issue_valid),
        .issue_op        (issue_op),
        .issue_byte_addr (issue_byte_addr),
        .issue_exc       (issue_exc)
    );

    data_ram #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) data_ram_i (
        .clk     (clk),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    lsu_load_align lsu_load_align_i (
        .clk             (clk),
        .rst             (rst),
        .bus_rsp         (bus_rsp),
        .issue_valid     (issue_valid),
        .issue_op        (issue_op),
        .issue_byte_addr (issue_byte_addr),
        .issue_exc       (issue_exc),
        .rsp_ready       (rsp_ready),
        .rsp             (rsp),
        .rsp_valid       (rsp_valid),
        .rsp_busy        (rsp_busy)
    );

endmodule

`default_nettype wire

//--- tb/lsu_checker.sv
// LSU response checker
// Shadow byte memory, expected responses in request order, protocol checks
`timescale 1ns/100ps
`default_nettype none

module lsu_checker import bus_pkg::*, lsu_pkg::*; #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  lsu_req_t req,
    input  logic     req_valid,
    input  logic     req_ready,
    input  mem_exc_t exp_exc,
    input  lsu_rsp_t rsp,
    input  logic     rsp_valid,
    input  logic     rsp_ready,
    output int       pass_cnt,
    output int       fail_cnt,
    output int       outstanding
);

    // Byte addresses wrap at the RAM size
    localparam addr_t ADDR_MASK = addr_t'((1 << (DEPTH_LOG2 + 2)) - 1);

    typedef struct packed {
        logic     is_store;
        mem_op_t  op;
        addr_t    addr;
        word_t    rdata;
        logic     check_data;
        mem_exc_t exc;
    } expect_t;

    logic [7:0] shadow [int];
    expect_t    exp_q [$];
    lsu_rsp_t   last_rsp;
    logic       stalled;
    int         rsp_cnt;

    initial begin
        pass_cnt    = 0;
        fail_cnt    = 0;
        outstanding = 0;
        rsp_cnt     = 0;
        stalled     = 1'b0;
    end

    // --------------------
    // Reference model
    // --------------------

    function automatic int size_bytes(mem_op_t op);
        case (op[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [7:0] byte_at(addr_t a);
        int idx;
        idx = int'(a & ADDR_MASK);
        if (shadow.exists(idx)) begin
            return shadow[idx];
        end
        return 8'bx;
    endfunction

    // Little endian, extension by opcode bit 2
    function automatic word_t expected_load(mem_op_t op, addr_t a);
        int    n;
        word_t v;
        logic  sign;
        n = size_bytes(op);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[8*k +: 8] = byte_at(a + addr_t'(k));
        end
        sign = ~op[2] & v[8*n-1];
        for (int k = n; k < 4; k++) begin
            v[8*k +: 8] = {8{sign}};
        end
        return v;
    endfunction

    task automatic record_request();
        expect_t e;
        e.is_store   = req.is_store;
        e.op         = req.op;
        e.addr       = req.address;
        e.exc        = exp_exc;
        e.check_data = !req.is_store && exp_exc == NONE;
        e.rdata      = '0;
        // Misaligned accesses leave the shadow alone
        if (exp_exc == NONE && req.is_store) begin
            for (int k = 0; k < size_bytes(req.op); k++) begin
                shadow[int'((req.address + addr_t'(k)) & ADDR_MASK)] = req.wdata[8*k +: 8];
            end
        end else if (exp_exc == NONE) begin
            e.rdata = expected_load(req.op, req.address);
        end
        exp_q.push_back(e);
    endtask

    task automatic compare_response(expect_t e);
        logic ok;
        ok = (rsp.exc === e.exc) && (!e.check_data || rsp.rdata === e.rdata);
        rsp_cnt++;
        if (ok) begin
            pass_cnt++;
            $display("[PASS] %0t: #%0d %s op %b addr %h rdata %h exc %0d", $time, rsp_cnt,
                     e.is_store ? "store" : "load", e.op, e.addr, rsp.rdata, rsp.exc);
        end else begin
            fail_cnt++;
            $display("[FAIL] %0t: #%0d %s op %b addr %h got %h exc %0d, expected %h exc %0d",
                     $time, rsp_cnt, e.is_store ? "store" : "load", e.op, e.addr,
                     rsp.rdata, rsp.exc, e.rdata, e.exc);
        end
    endtask

    // --------------------
    // Port monitor
    // --------------------

    always @(posedge clk) begin : watch
        expect_t e;
        if (rst) begin
            stalled = 1'b0;
        end else begin
            // Held response must not move
            if (stalled && !(rsp_valid && rsp === last_rsp)) begin
                $display("Response changed or dropped while rsp_ready was low at %0t", $time);
                fail_cnt++;
            end
            if (rsp_valid && !rsp_ready && req_ready) begin
                $display("req_ready was high while a response was stalled at %0t", $time);
                fail_cnt++;
            end
            stalled  = rsp_valid && !rsp_ready;
            last_rsp = rsp;
            // Old response leaves before a new request is logged
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Extra response at %0t with no request outstanding", $time);
                    fail_cnt++;
                end else begin
                    e = exp_q.pop_front();
                    compare_response(e);
                end
            end
            if (req_valid && req_ready) begin
                record_request();
            end
            outstanding = exp_q.size();
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_lsu.sv
// LSU testbench top
// Table-driven loads and stores with response stalls and a cycle limit
`timescale 1ns/100ps
`default_nettype none

module tb_lsu import bus_pkg::*, lsu_pkg::*;;

    localparam int DEPTH_LOG2   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int SEED         = 54427;
    // Table stalls stay at or below MAX_STALL
    localparam int MAX_STALL    = 3;
    localparam int RAND_STALL   = 2;

    typedef struct packed {
        logic       is_store;
        mem_op_t    op;
        addr_t      addr;
        word_t      wdata;
        mem_exc_t   exc;
        logic [3:0] stall;
    } row_t;

    logic     clk;
    logic     rst;
    lsu_req_t req;
    logic     req_valid;
    logic     req_ready;
    lsu_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;
    mem_exc_t exp_exc;
    int       pass_cnt;
    int       fail_cnt;
    int       outstanding;
    int       cycles;
    int       limit;
    row_t     rows [$];
    int       stall_q [$];

    lsu_top #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) lsu_top_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    lsu_checker #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) lsu_checker_i (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .exp_exc     (exp_exc),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .pass_cnt    (pass_cnt),
        .fail_cnt    (fail_cnt),
        .outstanding (outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_row(input logic is_store, input mem_op_t op, input addr_t addr,
                           input word_t wdata, input mem_exc_t exc, input int stall);
        row_t r;
        r.is_store = is_store;
        r.op       = op;
        r.addr     = addr;
        r.wdata    = wdata;
        r.exc      = exc;
        r.stall    = 4'(stall);
        rows.push_back(r);
    endtask

    // --------------------
    // Stimulus table
    // --------------------

    task automatic build_table();
        // Word store and load back
        add_row(1'b1, LW,  32'h10, 32'hA5A5_1234, NONE, 0);
        add_row(1'b0, LW,  32'h10, 32'h0,         NONE, 2);
        // One lane at a time, upper wdata bits are junk
        add_row(1'b1, LW,  32'h20, 32'h1122_3344, NONE, 0);
        add_row(1'b1, LB,  32'h20, 32'hDEAD_BEF0, NONE, 0);
        add_row(1'b0, LW,  32'h20, 32'h0,         NONE, 0);
        add_row(1'b1, LB,  32'h21, 32'h5555_558E, NONE, 1);
        add_row(1'b0, LW,  32'h20, 32'h0,         NONE, 0);
        add_row(1'b1, LB,  32'h22, 32'hFFFF_FF7C, NONE, 0);
        add_row(1'b0, LW,  32'h20, 32'h0,         NONE, 0);
        // Store with bit 2 set, same as SB
        add_row(1'b1, LBU, 32'h23, 32'h0000_0085, NONE, 3);
        add_row(1'b0, LW,  32'h20, 32'h0,         NONE, 1);
        add_row(1'b0, LB,  32'h20, 32'h0,         NONE, 0);
        add_row(1'b0, LBU, 32'h20, 32'h0,         NONE, 0);
        add_row(1'b0, LB,  32'h21, 32'h0,         NONE, 0);
        add_row(1'b0, LBU, 32'h21, 32'h0,         NONE, 1);
        add_row(1'b0, LB,  32'h22, 32'h0,         NONE, 0);
        add_row(1'b0, LBU, 32'h22, 32'h0,         NONE, 0);
        add_row(1'b0, LB,  32'h23, 32'h0,         NONE, 2);
        add_row(1'b0, LBU, 32'h23, 32'h0,         NONE, 0);
        // Halfwords, sign bit set in the lower half only
        add_row(1'b1, LH,  32'h30, 32'h1234_8001, NONE, 0);
        add_row(1'b1, LHU, 32'h32, 32'hABCD_7FFE, NONE, 1);
        add_row(1'b0, LW,  32'h30, 32'h0,         NONE, 0);
        add_row(1'b0, LH,  32'h30, 32'h0,         NONE, 0);
        add_row(1'b0, LHU, 32'h30, 32'h0,         NONE, 0);
        add_row(1'b0, LH,  32'h32, 32'h0,         NONE, 3);
        add_row(1'b0, LHU, 32'h32, 32'h0,         NONE, 0);
        // Misaligned, memory must stay intact
        add_row(1'b1, LW,  32'h40, 32'hCAFE_F00D, NONE, 0);
        add_row(1'b1, LW,  32'h42, 32'h1111_1111, STORE_MISALIGNED, 2);
        add_row(1'b1, LH,  32'h41, 32'h0000_2222, STORE_MISALIGNED, 0);
        add_row(1'b1, LW,  32'h43, 32'h3333_3333, STORE_MISALIGNED, 0);
        add_row(1'b0, LW,  32'h41, 32'h0,         LOAD_MISALIGNED,  1);
        add_row(1'b0, LH,  32'h43, 32'h0,         LOAD_MISALIGNED,  0);
        add_row(1'b0, LHU, 32'h45, 32'h0,         LOAD_MISALIGNED,  0);
        add_row(1'b0, LW,  32'h40, 32'h0,         NONE, 0);
        // Address above the RAM size wraps
        add_row(1'b1, LW,  32'h410, 32'h0BAD_CAFE, NONE, 0);
        add_row(1'b0, LW,  32'h010, 32'h0,         NONE, 0);
    endtask

    // --------------------
    // Request driver
    // --------------------

    initial begin
        rst       = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        exp_exc   = NONE;
        limit     = 0;
        void'($urandom(SEED));
        build_table();
        limit = rows.size() * (MAX_STALL + RAND_STALL + 3) + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            req.is_store <= rows[i].is_store;
            req.op       <= rows[i].op;
            req.address  <= rows[i].addr;
            req.wdata    <= rows[i].wdata;
            exp_exc      <= rows[i].exc;
            req_valid    <= 1'b1;
            @(posedge clk);
            while (!req_ready) @(posedge clk);
            stall_q.push_back(int'(rows[i].stall) + int'($urandom_range(RAND_STALL, 0)));
            @(negedge clk);
        end
        req_valid <= 1'b0;
        while (outstanding != 0) @(negedge clk);
        repeat (3) @(negedge clk);
        $display("Responses checked: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Response back-pressure, one stall count per response
    initial begin : ready_drive
        int   remaining;
        logic active;
        remaining = 0;
        active    = 1'b0;
        forever begin
            @(negedge clk);
            if (rsp_valid && !active && stall_q.size() > 0) begin
                active    = 1'b1;
                remaining = stall_q.pop_front();
            end
            if (active && remaining > 0) begin
                rsp_ready <= 1'b0;
                remaining--;
            end else begin
                rsp_ready <= 1'b1;
                active = 1'b0;
            end
        end
    end

    // Cycle limit
    initial begin
        cycles = 0;
        while (limit == 0 || cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d responses still missing", cycles, outstanding);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
common/bus_pkg.sv
common/lsu_pkg.sv
lsu/lsu_request.sv
lsu/lsu_load_align.sv
source/data_ram.sv
source/lsu_top.sv
tb/lsu_checker.sv
tb/tb_lsu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_lsu -o tb_lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All tests passed!$" "$LOG"; then
    echo "Result: PASS"
    exit 0
fi
echo "Result: FAIL"
exit 1
